// ==== common/bubble_pkg.sv ====
package bubble_pkg;

    //////////////////////////////
    // timing

    // blink half-period is BLINK_DIV+1 clocks
    localparam logic [12:0] BLINK_DIV      = 13'd4096;
    localparam int          SETTLE_TOGGLES = 4;     // blink toggles before evaluation
    localparam int          DELAY_UNIT     = 1024;  // clocks per delay_sel step

    // wide enough for 3 x DELAY_UNIT
    localparam int          DELAY_CNT_W    = $clog2(4 * DELAY_UNIT);

    //////////////////////////////
    // latched configuration

    // switch inputs are active low, stored inverted
    typedef struct packed {
        logic       bitwidth4;      // 4 bit bubble mode
        logic       bout_timing;
        logic       rom_select;     // flash or fram
        logic       fan_en;
        logic [1:0] delay_sel;      // start-up delay steps
        logic [3:0] image_number;
    } dip_settings_t;

    // core enables, active high
    typedef struct packed {
        logic emu_en;
        logic delay_en;
        logic fifo_en;
        logic mpsse_en;
    } core_enables_t;

    // led requests from the supervisor
    typedef struct packed {
        logic pwrok_on;
        logic pwrok_blink;
        logic standby_blink;
        logic delaying_on;
    } led_ctrl_t;

    //////////////////////////////
    // supervisor states

    typedef enum logic [2:0] {
        ST_LATCH,       // capture switches
        ST_WAIT,        // settling interval
        ST_EVAL,        // pick mode from power inputs
        ST_EMULATE,
        ST_STANDBY,     // usb serial engine only
        ST_ERR_BOARD,   // board reports power off
        ST_ERR_AMBIG    // usb powered but board on
    } boot_state_t;

endpackage

// ==== verilog/blinker.sv ====
module blinker
    import bubble_pkg::*;
(
    input  logic       MCLK,
    input  logic       MRST,
    input  logic       blink_run,
    output logic       blink_level,
    output logic [1:0] toggle_count
);

    logic [$bits(BLINK_DIV)-1:0] div_cnt;   // clocks within one half-period

    always_ff @(posedge MCLK)
    begin
        if (MRST)
        begin
            div_cnt      <= '0;
            blink_level  <= 1'b1;
            toggle_count <= '0;
        end
        else if (!blink_run)
        begin
            // stopped: idle level, counters cleared
            div_cnt      <= '0;
            blink_level  <= 1'b1;
            toggle_count <= '0;
        end
        else if (div_cnt == BLINK_DIV)
        begin
            div_cnt      <= '0;
            blink_level  <= ~blink_level;
            toggle_count <= toggle_count + 2'd1;    // wraps after 4
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

// ==== startup/startup_ctrl.sv ====
module startup_ctrl
    import bubble_pkg::*;
(
    input  logic          MCLK,
    input  logic          MRST,
    input  logic [3:0]    settings_sw,
    input  logic [1:0]    delay_sw,
    input  logic [3:0]    img_sel_sw,
    input  logic          pwr_usb,
    input  logic          board_off,
    input  logic [1:0]    toggle_count,
    output logic          blink_run,
    output core_enables_t core_en,
    output dip_settings_t settings,
    output led_ctrl_t     led_ctrl
);

    boot_state_t state;
    logic        last_toggle;   // previous cycle held the final count before wrap
    logic [1:0]  pwr_stat;

    assign pwr_stat = {pwr_usb, board_off};

    // blinker runs while waiting and in the blinking modes
    assign blink_run = (state == ST_WAIT) || (state == ST_STANDBY) ||
                       (state == ST_ERR_BOARD) || (state == ST_ERR_AMBIG);

    //////////////////////////////
    // state flow

    always_ff @(posedge MCLK)
    begin
        if (MRST)
        begin
            last_toggle <= 1'b0;
        end
        else
        begin
            last_toggle <= (state == ST_WAIT) &&
                           (toggle_count == 2'(SETTLE_TOGGLES - 1));
        end
    end

    always_ff @(posedge MCLK)
    begin
        if (MRST)
        begin
            state <= ST_LATCH;
        end
        else
        begin
            case (state)
                ST_LATCH:
                    state <= ST_WAIT;
                ST_WAIT:
                    if (last_toggle && toggle_count == 2'd0)
                    begin
                        state <= ST_EVAL;   // counter wrapped on the last toggle
                    end
                ST_EVAL:
                    case (pwr_stat)
                        2'b00:   state <= ST_EMULATE;
                        2'b01:   state <= ST_ERR_BOARD;
                        2'b10:   state <= ST_ERR_AMBIG;
                        default: state <= ST_STANDBY;
                    endcase
                ST_EMULATE:
                    state <= ST_EMULATE;    // held until reset
                ST_STANDBY:
                    if (pwr_stat != 2'b11)
                    begin
                        state <= ST_LATCH;
                    end
                ST_ERR_BOARD:
                    if (pwr_stat != 2'b01)
                    begin
                        state <= ST_LATCH;
                    end
                ST_ERR_AMBIG:
                    if (pwr_stat != 2'b10)
                    begin
                        state <= ST_LATCH;
                    end
                default:
                    state <= ST_LATCH;
            endcase
        end
    end

    //////////////////////////////
    // switch latch and outputs

    always_ff @(posedge MCLK)
    begin
        if (state == ST_LATCH)
        begin
            settings <= {~settings_sw, ~delay_sw, ~img_sel_sw};
        end
    end

    always_ff @(posedge MCLK)
    begin
        if (MRST)
        begin
            core_en  <= '0;
            led_ctrl <= '0;
        end
        else
        begin
            core_en  <= '0;
            led_ctrl <= '0;
            case (state)
                ST_EMULATE:
                begin
                    core_en.emu_en       <= 1'b1;
                    core_en.delay_en     <= 1'b1;
                    core_en.fifo_en      <= 1'b1;
                    led_ctrl.pwrok_on    <= 1'b1;
                    led_ctrl.delaying_on <= 1'b1;
                end
                ST_STANDBY:
                begin
                    core_en.mpsse_en       <= 1'b1;
                    led_ctrl.standby_blink <= 1'b1;
                end
                ST_WAIT, ST_ERR_BOARD, ST_ERR_AMBIG:
                    led_ctrl.pwrok_blink <= 1'b1;
                default:
                    led_ctrl <= '0;     // latch and eval, all dark
            endcase
        end
    end

    // emulator and usb engine share the fifo bus
    a_emu_mpsse_excl: assert property (@(posedge MCLK) disable iff (MRST)
        !(core_en.emu_en && core_en.mpsse_en));

endmodule

// ==== startup/boot_delay.sv ====
module boot_delay
    import bubble_pkg::*;
(
    input  logic          MCLK,
    input  logic          MRST,
    input  core_enables_t core_en,
    input  dip_settings_t settings,
    input  logic          push_sw,
    output logic          delaying,
    output logic          drive_ready
);

    logic                   delay_en_q;
    logic                   delay_rise;
    logic [DELAY_CNT_W-1:0] load_val;
    logic [DELAY_CNT_W-1:0] count;
    logic [DELAY_CNT_W-1:0] count_next;

    assign delay_rise = core_en.delay_en && !delay_en_q;
    assign load_val   = DELAY_CNT_W'(settings.delay_sel) * DELAY_CNT_W'(DELAY_UNIT);
    assign delaying   = (count != '0);

    always_comb
    begin
        if (!core_en.delay_en)
        begin
            count_next = '0;
        end
        else if (delay_rise)
        begin
            count_next = load_val;
        end
        else if (push_sw || count == '0)
        begin
            count_next = '0;    // button skips the rest
        end
        else
        begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge MCLK)
    begin
        if (MRST)
        begin
            delay_en_q  <= 1'b0;
            count       <= '0;
            drive_ready <= 1'b0;
        end
        else
        begin
            delay_en_q  <= core_en.delay_en;
            count       <= count_next;
            drive_ready <= core_en.delay_en && (count_next == '0);
        end
    end

    // counter only runs under the supervisor's enable
    a_delay_needs_en: assert property (@(posedge MCLK) disable iff (MRST)
        delaying |-> core_en.delay_en);

endmodule

// ==== verilog/status_leds.sv ====
module status_leds
    import bubble_pkg::*;
(
    input  led_ctrl_t led_ctrl,
    input  logic      blink_level,
    input  logic      delaying,
    output logic      led_pwrok_n,
    output logic      led_standby_n,
    output logic      led_delaying_n
);

    logic blink_on;     // lit phase of the blinker

    assign blink_on = ~blink_level;

    // all pins active low
    assign led_pwrok_n    = ~(led_ctrl.pwrok_on ||
                              (led_ctrl.pwrok_blink && blink_on));

    // standby also shows the start-up delay
    assign led_standby_n  = ~((led_ctrl.standby_blink && blink_on) || delaying);

    assign led_delaying_n = ~(led_ctrl.delaying_on && delaying);

endmodule

// ==== verilog/bubble_top.sv ====
module bubble_top
    import bubble_pkg::*;
(
    input  logic          MCLK,
    input  logic          MRST,
    input  logic [3:0]    settings_sw,
    input  logic [1:0]    delay_sw,
    input  logic [3:0]    img_sel_sw,
    input  logic          push_sw,
    input  logic          pwr_usb,
    input  logic          board_off,
    output core_enables_t core_en,
    output dip_settings_t settings,
    output logic          drive_ready,
    output logic          n4ben,
    output logic          led_pwrok_n,
    output logic          led_standby_n,
    output logic          led_delaying_n
);

    logic       blink_run;
    logic       blink_level;
    logic [1:0] toggle_count;
    led_ctrl_t  led_ctrl;
    logic       delaying;

    assign n4ben = settings_sw[3];  // straight from the switch

    //////////////////////////////
    // supervisor

    startup_ctrl startup_ctrl_inst (
        .MCLK         (MCLK),
        .MRST         (MRST),
        .settings_sw  (settings_sw),
        .delay_sw     (delay_sw),
        .img_sel_sw   (img_sel_sw),
        .pwr_usb      (pwr_usb),
        .board_off    (board_off),
        .toggle_count (toggle_count),
        .blink_run    (blink_run),
        .core_en      (core_en),
        .settings     (settings),
        .led_ctrl     (led_ctrl)
    );

    blinker blinker_inst (
        .MCLK         (MCLK),
        .MRST         (MRST),
        .blink_run    (blink_run),
        .blink_level  (blink_level),
        .toggle_count (toggle_count)
    );

    //////////////////////////////
    // delay and leds

    boot_delay boot_delay_inst (
        .MCLK        (MCLK),
        .MRST        (MRST),
        .core_en     (core_en),
        .settings    (settings),
        .push_sw     (push_sw),
        .delaying    (delaying),
        .drive_ready (drive_ready)
    );

    status_leds status_leds_inst (
        .led_ctrl       (led_ctrl),
        .blink_level    (blink_level),
        .delaying       (delaying),
        .led_pwrok_n    (led_pwrok_n),
        .led_standby_n  (led_standby_n),
        .led_delaying_n (led_delaying_n)
    );

endmodule

// ==== verification/tb_clock.sv ====
module tb_clock
(
    output logic MCLK
);

    localparam int HALF_PERIOD = 4;     // 8 unit period

    initial
    begin
        MCLK = 1'b0;
    end

    always
    begin
        #HALF_PERIOD MCLK = ~MCLK;
    end

endmodule

// ==== verification/bubble_tb.sv ====
module bubble_tb
    import bubble_pkg::*;
;

    localparam int HALF      = int'(BLINK_DIV) + 1;       // blink half-period in clocks
    localparam int SETTLE    = SETTLE_TOGGLES * HALF;
    localparam int SETTLE_HI = SETTLE + 8;
    localparam int TEST_LEN  = SETTLE_HI + 3 * HALF + 3 * DELAY_UNIT;
    localparam int NUM_RUNS  = 9;                          // settle windows over all tests
    localparam int LIMIT     = NUM_RUNS * TEST_LEN * 12 / 10;

    localparam logic [3:0] EN_EMU  = 4'b1110;   // emu, delay, fifo
    localparam logic [3:0] EN_STBY = 4'b0001;   // mpsse only

    logic          MCLK;
    logic          MRST;
    logic [3:0]    settings_sw;
    logic [1:0]    delay_sw;
    logic [3:0]    img_sel_sw;
    logic          push_sw;
    logic          pwr_usb;
    logic          board_off;
    core_enables_t core_en;
    dip_settings_t settings;
    logic          drive_ready;
    logic          n4ben;
    logic          led_pwrok_n;
    logic          led_standby_n;
    logic          led_delaying_n;

    logic [31:0] lfsr;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          cycles;

    tb_clock tb_clock_inst (.MCLK(MCLK));

    bubble_top bubble_top_inst (
        .MCLK           (MCLK),
        .MRST           (MRST),
        .settings_sw    (settings_sw),
        .delay_sw       (delay_sw),
        .img_sel_sw     (img_sel_sw),
        .push_sw        (push_sw),
        .pwr_usb        (pwr_usb),
        .board_off      (board_off),
        .core_en        (core_en),
        .settings       (settings),
        .drive_ready    (drive_ready),
        .n4ben          (n4ben),
        .led_pwrok_n    (led_pwrok_n),
        .led_standby_n  (led_standby_n),
        .led_delaying_n (led_delaying_n)
    );

    //////////////////////////////
    // helpers

    // taps 32 22 2 1
    task automatic rand_bits(input int n, output logic [31:0] v);
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
    endtask

    // switches are active low, latched inverted
    function automatic dip_settings_t model_settings(input logic [3:0] sw,
                                                     input logic [1:0] dsw,
                                                     input logic [3:0] isw);
        dip_settings_t s;
        s.bitwidth4    = ~sw[3];
        s.bout_timing  = ~sw[2];
        s.rom_select   = ~sw[1];
        s.fan_en       = ~sw[0];
        s.delay_sel    = ~dsw;
        s.image_number = ~isw;
        return s;
    endfunction

    task automatic fail(input string msg);
        $display("[FAIL] t=%0t %s", $time, msg);
        errors++;
    endtask

    task automatic tick();
        @(posedge MCLK);
        #1;
        if (n4ben !== settings_sw[3])
            fail("n4ben does not follow settings_sw[3]");
    endtask

    task automatic random_switches();
        logic [31:0] v;
        rand_bits(10, v);
        settings_sw = v[9:6];
        delay_sw    = v[5:4];
        img_sel_sw  = v[3:0];
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_errors)
            $display("test %s ok", name);
        else
            $display("test %s FAILED with %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic do_reset();
        MRST = 1'b1;
        for (int i = 0; i < 3; i++)
        begin
            tick();
            if (core_en !== 4'b0 || drive_ready !== 1'b0)
                fail("enables or drive_ready high in reset");
            if ({led_pwrok_n, led_standby_n, led_delaying_n} !== 3'b111)
                fail("led lit in reset");
        end
        MRST = 1'b0;
    endtask

    // counts clocks until any enable shows up
    task automatic wait_for_mode(output int n);
        n = 0;
        do
        begin
            tick();
            n++;
        end
        while (core_en == 4'b0 && n < SETTLE_HI + 32);
        if (core_en == 4'b0)
            $display("ERROR: no enable rose within the settle window");
        if (core_en == 4'b0)
            errors++;
        else if (n < SETTLE || n > SETTLE_HI)
            fail($sformatf("mode entered after %0d clocks", n));
    endtask

    // led must be seen lit and dark while enables hold
    task automatic watch_blink(input logic is_pwrok, input logic [3:0] en_exp);
        logic seen_hi;
        logic seen_lo;
        logic led;
        seen_hi = 1'b0;
        seen_lo = 1'b0;
        for (int i = 0; i < 3 * HALF; i++)
        begin
            tick();
            led = is_pwrok ? led_pwrok_n : led_standby_n;
            if (led)
                seen_hi = 1'b1;
            else
                seen_lo = 1'b1;
            if (core_en !== en_exp)
                fail("enables changed while blinking");
        end
        if (!(seen_hi && seen_lo))
            fail("led did not blink");
    endtask

    //////////////////////////////
    // tests

    task automatic run_emulation(input logic use_push, input string name);
        dip_settings_t exp_s;
        int            n;
        int            k;
        int            load;
        int            push_at;
        int            limit;
        logic [31:0]   v;
        random_switches();
        if (use_push && delay_sw == 2'b11)
            delay_sw = 2'b10;   // keep a nonzero delay
        exp_s     = model_settings(settings_sw, delay_sw, img_sel_sw);
        pwr_usb   = 1'b0;
        board_off = 1'b0;
        do_reset();
        wait_for_mode(n);
        if (settings !== exp_s)
            fail("settings differ from inverted switches");
        if (core_en !== EN_EMU)
            fail("emulation enables wrong");
        if (led_pwrok_n !== 1'b0)
            fail("pwrok led not lit in emulation");
        load = int'(exp_s.delay_sel) * DELAY_UNIT;
        rand_bits(10, v);
        push_at = 2 + int'(v) % (load / 2 + 1);
        limit   = use_push ? push_at + 3 : load + 3;
        k = 0;
        while (!drive_ready && k < limit)
        begin
            tick();
            k++;
            push_sw = 1'b0;
            random_switches();      // latch must hold
            if (settings !== exp_s)
                fail("settings changed after latch");
            if (!drive_ready)
            begin
                if (led_delaying_n !== 1'b0 || led_standby_n !== 1'b0)
                    fail("delay leds dark while delay pending");
            end
            else if (led_delaying_n !== 1'b1 || led_standby_n !== 1'b1)
                fail("delay leds lit with drive_ready high");
            if (use_push && k == push_at)
                push_sw = 1'b1;
        end
        push_sw = 1'b0;
        if (!drive_ready)
            fail($sformatf("drive_ready missing after %0d clocks", k));
        else if (!use_push && k < load)
            fail($sformatf("drive_ready early at %0d, delay %0d", k, load));
        else if (use_push && k <= push_at)
            fail($sformatf("drive_ready at %0d before push at %0d", k, push_at));
        tick();
        if (led_delaying_n !== 1'b1 || led_standby_n !== 1'b1)
            fail("delay leds lit after drive_ready");
        end_test(name);
    endtask

    task automatic run_standby();
        dip_settings_t exp_s;
        int            n;
        random_switches();
        pwr_usb   = 1'b1;
        board_off = 1'b1;
        do_reset();
        wait_for_mode(n);
        if (core_en !== EN_STBY)
            fail("standby enables wrong");
        watch_blink(1'b0, EN_STBY);
        random_switches();
        exp_s   = model_settings(settings_sw, delay_sw, img_sel_sw);
        pwr_usb = 1'b0;
        tick();
        tick();
        tick();
        if (core_en !== 4'b0)
            fail("enables not low after pwr_usb dropped");
        board_off = 1'b0;
        wait_for_mode(n);
        if (core_en !== EN_EMU || settings !== exp_s)
            fail("no emulation after re-evaluation");
        end_test("standby");
    endtask

    task automatic run_fault(input logic usb, input logic off, input string name);
        int n;
        random_switches();
        pwr_usb   = usb;
        board_off = off;
        do_reset();
        for (int i = 0; i < SETTLE_HI + 8; i++)
        begin
            tick();
            if (core_en !== 4'b0)
                fail("enable high in fault state");
        end
        watch_blink(1'b1, 4'b0);
        pwr_usb   = 1'b0;
        board_off = 1'b0;
        wait_for_mode(n);
        if (core_en !== EN_EMU)
            fail("no emulation after fault cleared");
        end_test(name);
    endtask

    //////////////////////////////
    // timeout

    always @(posedge MCLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT)
        begin
            $display("timeout: run exceeded %0d clocks", LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    initial
    begin
        lfsr        = 32'd32;
        errors      = 0;
        test_errors = 0;
        tests_run   = 0;
        cycles      = 0;
        MRST        = 1'b1;
        settings_sw = 4'hf;
        delay_sw    = 2'b11;
        img_sel_sw  = 4'hf;
        push_sw     = 1'b0;
        pwr_usb     = 1'b0;
        board_off   = 1'b0;

        do_reset();
        for (int i = 0; i < SETTLE - 1; i++)
        begin
            tick();
            if (core_en !== 4'b0 || drive_ready !== 1'b0)
                fail("enable or drive_ready rose before settle window");
            if (i == 0 && {led_pwrok_n, led_standby_n, led_delaying_n} !== 3'b111)
                fail("led lit just after reset");
        end
        end_test("reset");

        run_emulation(1'b0, "emulation");
        run_emulation(1'b1, "push_skip");
        run_standby();
        run_fault(1'b0, 1'b1, "fault_board");
        run_fault(1'b1, 1'b0, "fault_ambig");

        $display("tests %0d, errors %0d", tests_run, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// ==== filelist.f ====
common/bubble_pkg.sv
verilog/blinker.sv
startup/startup_ctrl.sv
startup/boot_delay.sv
verilog/status_leds.sv
verilog/bubble_top.sv
verification/tb_clock.sv
verification/bubble_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= bubble_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wall

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf $(OBJ_DIR)
